// ==== source/lc3b_macros.svh ====
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// ----------------------------------------
// Data memory geometry
// ----------------------------------------

// Sixteen bit words per line
`define LC3B_LINE_WORDS 8

// Line width in bits
`define LC3B_LINE_BITS 128

// Line index width for 64 lines of 16 bytes
`define LC3B_MEM_LINE_AW 6

`endif

// ==== source/lc3b_pkg.sv ====
`default_nettype none

package lc3b_pkg;

    // Data and address word
    typedef logic [15:0] lc3b_word;

    // Condition code bits {n, z, p}
    typedef logic [2:0] lc3b_cc;

    // Data address source
    typedef enum logic [1:0] {
        ADDR_TRAP = 2'd0,  // Trap vector shifted left by one
        ADDR_ALU  = 2'd1,
        ADDR_HELD = 2'd2   // Word held from an earlier read
    } lc3b_addr_sel;

    // Condition code source
    typedef enum logic [1:0] {
        CC_SRC_ALU   = 2'd0,
        CC_SRC_RDATA = 2'd1,  // Word read by this operation
        CC_SRC_STORE = 2'd2
    } lc3b_cc_sel;

    // ----------------------------------------
    // Instruction word views
    // ----------------------------------------
    typedef struct packed {
        logic [3:0] opcode;
        lc3b_cc     nzp;     // Condition mask in bits 11:9
        logic [8:0] offset;
    } lc3b_br_view;

    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] pad;
        logic [7:0] vector;  // Trap vector in bits 7:0
    } lc3b_trap_view;

    typedef union packed {
        lc3b_br_view   br;
        lc3b_trap_view trap;
    } lc3b_ir;

endpackage

`default_nettype wire

// ==== source/stage_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_macros.svh"

module stage_mem (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              start,
    input  wire                              mem_read,
    input  wire                              mem_write,
    input  wire  [1:0]                       byte_sel,
    input  wire  lc3b_pkg::lc3b_addr_sel     addr_sel,
    input  wire  lc3b_pkg::lc3b_cc_sel       cc_sel,
    input  wire                              cc_load,
    input  wire                              br_en_load,
    input  wire                              mdr_load,
    input  wire  lc3b_pkg::lc3b_word         alu_in,
    input  wire  lc3b_pkg::lc3b_ir           ir_in,
    input  wire  lc3b_pkg::lc3b_word         sr2_in,
    input  wire                              mem_ack,
    input  wire  [`LC3B_LINE_BITS-1:0]       mem_rdata,
    output logic [15:0]                      mdr,
    output logic                             br_en,
    output logic                             done,
    output logic                             mem_req,
    output logic [`LC3B_MEM_LINE_AW-1:0]     mem_line,
    output logic                             mem_we,
    output logic [`LC3B_LINE_BITS/8-1:0]     mem_sel,
    output logic [`LC3B_LINE_BITS-1:0]       mem_wdata
);

    localparam int LANE_W = $clog2(`LC3B_LINE_WORDS);

    typedef enum logic [1:0] {
        S_IDLE    = 2'd0,
        S_REQ     = 2'd1,  // Request up while waiting for ack
        S_RELEASE = 2'd2,  // Request down until ack falls
        S_FINISH  = 2'd3
    } state_t;

    state_t               state;
    lc3b_pkg::lc3b_cc     cc;
    lc3b_pkg::lc3b_word   held;
    lc3b_pkg::lc3b_word   addr;
    lc3b_pkg::lc3b_word   trap_addr;
    lc3b_pkg::lc3b_word   cc_src;
    lc3b_pkg::lc3b_word   rdata_lane;
    logic [LANE_W-1:0]    lane;
    logic                 is_read;

    // Sign and zero test of one word
    function automatic lc3b_pkg::lc3b_cc gen_cc(input lc3b_pkg::lc3b_word w);
        lc3b_pkg::lc3b_cc c;
        if (w[15]) begin
            c = 3'b100;
        end else if (w == 16'h0000) begin
            c = 3'b010;
        end else begin
            c = 3'b001;
        end
        return c;
    endfunction

    // ----------------------------------------
    // Address and request fields
    // ----------------------------------------
    assign trap_addr = {7'b0, ir_in.trap.vector, 1'b0};
    assign is_read   = mem_read & ~mem_write;  // A write takes priority

    always_comb begin
        case (addr_sel)
            lc3b_pkg::ADDR_TRAP: addr = trap_addr;
            lc3b_pkg::ADDR_HELD: addr = held;
            default:             addr = alu_in;
        endcase
    end

    assign lane     = addr[LANE_W:1];                         // Bit 0 ignored
    assign mem_line = addr[LANE_W+1 +: `LC3B_MEM_LINE_AW];
    assign mem_we   = mem_write;

    // Place byte enables and store word in the addressed lane
    always_comb begin
        mem_sel   = '0;
        mem_wdata = '0;
        mem_sel[lane*2 +: 2]    = byte_sel;
        mem_wdata[lane*16 +: 16] = sr2_in;
    end

    assign rdata_lane = mem_rdata[lane*16 +: 16];

    // ----------------------------------------
    // Requester FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= (mem_read || mem_write) ? S_REQ : S_FINISH;
                    end
                end
                S_REQ: begin
                    if (mem_ack) state <= S_RELEASE;
                end
                S_RELEASE: begin
                    if (!mem_ack) state <= S_FINISH;  // Responder has let go
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign mem_req = (state == S_REQ);
    assign done    = (state == S_FINISH);

    // Read lane captured while ack is high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mdr <= '0;
        end else if (state == S_REQ && mem_ack && is_read) begin
            mdr <= rdata_lane;
        end
    end

    // ----------------------------------------
    // Condition codes and branch enable
    // ----------------------------------------
    always_comb begin
        case (cc_sel)
            lc3b_pkg::CC_SRC_RDATA: cc_src = mdr;
            lc3b_pkg::CC_SRC_STORE: cc_src = sr2_in;
            default:                cc_src = alu_in;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cc    <= 3'b010;
            br_en <= 1'b0;
            held  <= '0;
        end else if (state == S_FINISH) begin
            if (cc_load) cc <= gen_cc(cc_src);
            // Compared against the code from before this operation
            if (br_en_load) br_en <= |(cc & ir_in.br.nzp);
            if (mdr_load && is_read) begin
                held <= mdr;  // Pointer for a later indirect access
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/line_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_macros.svh"

module line_memory (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           mem_req,
    input  wire  [`LC3B_MEM_LINE_AW-1:0]  mem_line,
    input  wire                           mem_we,
    input  wire  [`LC3B_LINE_BITS/8-1:0]  mem_sel,
    input  wire  [`LC3B_LINE_BITS-1:0]    mem_wdata,
    output logic                          mem_ack,
    output logic [`LC3B_LINE_BITS-1:0]    mem_rdata
);

    localparam int LINES      = 2 ** `LC3B_MEM_LINE_AW;
    localparam int LINE_BYTES = `LC3B_LINE_BITS / 8;

    logic [`LC3B_LINE_BITS-1:0] mem [LINES];
    logic                       new_req;

    // Request seen while not yet acknowledged
    assign new_req = mem_req & ~mem_ack;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < LINES; i++) begin
                mem[i] <= '0;
            end
        end else if (new_req && mem_we) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (mem_sel[b]) begin
                    mem[mem_line][b*8 +: 8] <= mem_wdata[b*8 +: 8];  // Enabled bytes only
                end
            end
        end
    end

    // Whole line registered for a read
    always_ff @(posedge clk) begin
        if (new_req && !mem_we) begin
            mem_rdata <= mem[mem_line];
        end
    end

    // ----------------------------------------
    // Responder side of the handshake
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ack <= 1'b0;
        end else if (new_req) begin
            mem_ack <= 1'b1;
        end else if (!mem_req) begin
            mem_ack <= 1'b0;  // Requester has dropped req
        end
    end

endmodule

`default_nettype wire

// ==== source/lc3b_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_macros.svh"

module lc3b_mem_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           start,
    input  wire                           mem_read,
    input  wire                           mem_write,
    input  wire  [1:0]                    byte_sel,
    input  wire  lc3b_pkg::lc3b_addr_sel  addr_sel,
    input  wire  lc3b_pkg::lc3b_cc_sel    cc_sel,
    input  wire                           cc_load,
    input  wire                           br_en_load,
    input  wire                           mdr_load,
    input  wire  lc3b_pkg::lc3b_word      alu_in,
    input  wire  lc3b_pkg::lc3b_ir        ir_in,
    input  wire  lc3b_pkg::lc3b_word      sr2_in,
    output wire  [15:0]                   mdr,
    output wire                           br_en,
    output wire                           done
);

    // Stage to memory handshake
    wire                          mem_req;
    wire                          mem_ack;
    wire [`LC3B_MEM_LINE_AW-1:0]  mem_line;
    wire                          mem_we;
    wire [`LC3B_LINE_BITS/8-1:0]  mem_sel;
    wire [`LC3B_LINE_BITS-1:0]    mem_wdata;
    wire [`LC3B_LINE_BITS-1:0]    mem_rdata;

    stage_mem u_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .byte_sel   (byte_sel),
        .addr_sel   (addr_sel),
        .cc_sel     (cc_sel),
        .cc_load    (cc_load),
        .br_en_load (br_en_load),
        .mdr_load   (mdr_load),
        .alu_in     (alu_in),
        .ir_in      (ir_in),
        .sr2_in     (sr2_in),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .mdr        (mdr),
        .br_en      (br_en),
        .done       (done),
        .mem_req    (mem_req),
        .mem_line   (mem_line),
        .mem_we     (mem_we),
        .mem_sel    (mem_sel),
        .mem_wdata  (mem_wdata)
    );

    line_memory u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_line  (mem_line),
        .mem_we    (mem_we),
        .mem_sel   (mem_sel),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== dv/lc3b_mem_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_macros.svh"

module lc3b_mem_assert (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          mem_req,
    input wire                          mem_ack,
    input wire [`LC3B_MEM_LINE_AW-1:0]  mem_line,
    input wire                          mem_we,
    input wire [`LC3B_LINE_BITS/8-1:0]  mem_sel,
    input wire [`LC3B_LINE_BITS-1:0]    mem_wdata,
    input wire                          done
);

    int fail_count = 0;  // Read by the testbench at the end of the run

    // ----------------------------------------
    // Four-phase handshake
    // ----------------------------------------
    req_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req)
        else begin
            fail_count++;
            $error("mem_req dropped before mem_ack");
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_ack) |-> $past(mem_req))
        else begin
            fail_count++;
            $error("mem_ack rose without a request");
        end

    // A new request waits for the previous ack to fall
    req_after_release: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req) |-> !mem_ack)
        else begin
            fail_count++;
            $error("mem_req raised while mem_ack still high");
        end

    fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && $past(mem_req) |-> $stable(mem_line) && $stable(mem_we)
            && $stable(mem_sel) && $stable(mem_wdata))
        else begin
            fail_count++;
            $error("request fields changed while mem_req was high");
        end

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            fail_count++;
            $error("done stayed high for more than one cycle");
        end

endmodule

bind stage_mem lc3b_mem_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_req   (mem_req),
    .mem_ack   (mem_ack),
    .mem_line  (mem_line),
    .mem_we    (mem_we),
    .mem_sel   (mem_sel),
    .mem_wdata (mem_wdata),
    .done      (done)
);

`default_nettype wire

// ==== dv/lc3b_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3b_mem_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int CC_ROUNDS   = 10;  // Each round visits all three sources
    localparam int FULL_WORDS  = 12;
    localparam int BYTE_ROUNDS = 8;
    localparam int TRAP_ROUNDS = 8;
    localparam int IND_ROUNDS  = 8;
    localparam int MIX_OPS     = 200;
    localparam int TOTAL_OPS   = 2 + 7 * CC_ROUNDS + 2 * FULL_WORDS + 3 * BYTE_ROUNDS
                                 + 2 * TRAP_ROUNDS + 4 * IND_ROUNDS + MIX_OPS;
    localparam int DONE_LIMIT  = 40;  // Cycles allowed per operation
    localparam longint WATCHDOG_NS = longint'(TOTAL_OPS * 20 + 200) * CLK_PERIOD;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   start;
    logic                   mem_read;
    logic                   mem_write;
    logic [1:0]             byte_sel;
    lc3b_pkg::lc3b_addr_sel addr_sel;
    lc3b_pkg::lc3b_cc_sel   cc_sel;
    logic                   cc_load;
    logic                   br_en_load;
    logic                   mdr_load;
    logic [15:0]            alu_in;
    logic [15:0]            ir_in;
    logic [15:0]            sr2_in;
    wire  [15:0]            mdr;
    wire                    br_en;
    wire                    done;

    // Reference model state
    logic [15:0] model_mem [512];  // Indexed by address bits 9:1
    logic [2:0]  model_cc;
    logic        model_br_en;
    logic [15:0] model_held;
    logic [15:0] model_mdr;

    logic [31:0] lfsr = 32'h2df4_ce7b;
    int          test_checks;
    int          test_errors;
    int          total_checks = 0;
    int          total_errors = 0;

    lc3b_mem_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .byte_sel   (byte_sel),
        .addr_sel   (addr_sel),
        .cc_sel     (cc_sel),
        .cc_load    (cc_load),
        .br_en_load (br_en_load),
        .mdr_load   (mdr_load),
        .alu_in     (alu_in),
        .ir_in      (ir_in),
        .sr2_in     (sr2_in),
        .mdr        (mdr),
        .br_en      (br_en),
        .done       (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // Random numbers and helpers
    // ----------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // Galois step
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [15:0] rand_word();
        logic [31:0] r;
        r = rand_bits(16);
        return r[15:0];
    endfunction

    // Zero one time in four so the z flag gets exercised
    function automatic logic [15:0] cc_word();
        if (rand_bits(2) == 32'd0) begin
            return 16'h0000;
        end
        return rand_word();
    endfunction

    function automatic logic [2:0] nzp_of(input logic [15:0] w);
        return {w[15], w == 16'h0000, !w[15] && w != 16'h0000};
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        test_checks++;
        if (act !== exp) begin
            test_errors++;
            $display("CHECK FAILED: %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    // ----------------------------------------
    // Reference model of one operation
    // ----------------------------------------
    task automatic model_op(input logic rd, input logic wr, input logic [1:0] bsel,
                            input lc3b_pkg::lc3b_addr_sel asel,
                            input lc3b_pkg::lc3b_cc_sel csel, input logic [2:0] loads,
                            input logic [15:0] alu, input logic [15:0] ir,
                            input logic [15:0] sr2);
        logic [15:0] addr;
        logic [8:0]  idx;
        logic [2:0]  old_cc;
        logic [15:0] src;
        case (asel)
            lc3b_pkg::ADDR_TRAP: addr = {8'h00, ir[7:0]} << 1;
            lc3b_pkg::ADDR_HELD: addr = model_held;
            default:             addr = alu;
        endcase
        idx = addr[9:1];
        if (wr) begin
            if (bsel[0]) model_mem[idx][7:0]  = sr2[7:0];
            if (bsel[1]) model_mem[idx][15:8] = sr2[15:8];
        end else if (rd) begin
            model_mdr = model_mem[idx];
        end
        old_cc = model_cc;
        case (csel)
            lc3b_pkg::CC_SRC_RDATA: src = model_mdr;
            lc3b_pkg::CC_SRC_STORE: src = sr2;
            default:                src = alu;
        endcase
        if (loads[2]) model_cc = nzp_of(src);
        if (loads[1]) model_br_en = |(old_cc & ir[11:9]);  // Mask against the old code
        if (loads[0] && rd && !wr) model_held = model_mdr;
    endtask

    // Drive one operation, wait for done, then compare with the model
    task automatic run_op(input logic rd, input logic wr, input logic [1:0] bsel,
                          input lc3b_pkg::lc3b_addr_sel asel,
                          input lc3b_pkg::lc3b_cc_sel csel, input logic [2:0] loads,
                          input logic [15:0] alu, input logic [15:0] ir,
                          input logic [15:0] sr2);
        int waited;
        mem_read   = rd;
        mem_write  = wr;
        byte_sel   = bsel;
        addr_sel   = asel;
        cc_sel     = csel;
        {cc_load, br_en_load, mdr_load} = loads;
        alu_in     = alu;
        ir_in      = ir;
        sr2_in     = sr2;
        start      = 1'b1;
        @(posedge clk);
        #10;
        start  = 1'b0;
        waited = 0;
        while (!done && waited < DONE_LIMIT) begin
            @(posedge clk);
            #10;
            waited++;
        end
        if (!done) begin
            test_errors++;
            $display("ERROR: operation did not complete within %0d cycles", DONE_LIMIT);
        end else begin
            @(posedge clk);  // CC, br_en and held word settle on the done cycle
            #10;
            model_op(rd, wr, bsel, asel, csel, loads, alu, ir, sr2);
            check_value("mdr", model_mdr, mdr);
            check_value("br_en", {15'b0, model_br_en}, {15'b0, br_en});
        end
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic begin_test();
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_cond_codes();
        logic [15:0] v;
        check_value("mdr", 16'h0000, mdr);
        check_value("done", 16'h0000, {15'b0, done});
        // Reset code is z only
        run_op(1'b0, 1'b0, 2'b00, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b010,
               16'h0000, 16'h0400, 16'h0000);
        run_op(1'b0, 1'b0, 2'b00, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b010,
               16'h0000, 16'h0a00, 16'h0000);
        for (int i = 0; i < CC_ROUNDS; i++) begin
            v = cc_word();
            run_op(1'b0, 1'b0, 2'b00, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b100,
                   v, rand_word(), rand_word());
            run_op(1'b0, 1'b0, 2'b00, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b010,
                   rand_word(), rand_word(), rand_word());
            v = cc_word();
            run_op(1'b0, 1'b1, 2'b11, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_STORE, 3'b100,
                   {6'b0, i[5:0], 4'h0}, rand_word(), v);
            run_op(1'b0, 1'b0, 2'b00, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b010,
                   rand_word(), rand_word(), rand_word());
            v = cc_word();
            run_op(1'b0, 1'b1, 2'b11, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b000,
                   {6'b0, i[5:0], 4'h2}, rand_word(), v);
            run_op(1'b1, 1'b0, 2'b00, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_RDATA, 3'b100,
                   {6'b0, i[5:0], 4'h2}, rand_word(), rand_word());
            run_op(1'b0, 1'b0, 2'b00, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b010,
                   rand_word(), rand_word(), rand_word());
        end
    endtask

    task automatic test_full_words();
        logic [15:0] addrs [FULL_WORDS];
        for (int i = 0; i < FULL_WORDS; i++) begin
            addrs[i] = rand_word();
            run_op(1'b0, 1'b1, 2'b11, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b000,
                   addrs[i], rand_word(), rand_word());
        end
        for (int i = 0; i < FULL_WORDS; i++) begin
            run_op(1'b1, 1'b0, 2'b00, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b000,
                   addrs[i], rand_word(), rand_word());
        end
    endtask

    task automatic test_byte_lanes();
        logic [15:0] a;
        logic [1:0]  bsel;
        for (int i = 0; i < BYTE_ROUNDS; i++) begin
            a    = rand_word();
            bsel = (rand_bits(1) == 32'd1) ? 2'b01 : 2'b10;
            run_op(1'b0, 1'b1, 2'b11, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b000,
                   a, rand_word(), rand_word());
            run_op(1'b0, 1'b1, bsel, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b000,
                   a, rand_word(), rand_word());
            run_op(1'b1, 1'b0, 2'b00, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b000,
                   a, rand_word(), rand_word());
        end
    endtask

    task automatic test_trap_vector();
        logic [31:0] r;
        logic [7:0]  vec;
        for (int i = 0; i < TRAP_ROUNDS; i++) begin
            r   = rand_bits(8);
            vec = r[7:0];
            run_op(1'b0, 1'b1, 2'b11, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b000,
                   {7'b0, vec, 1'b0}, rand_word(), rand_word());
            r = rand_bits(8);
            run_op(1'b1, 1'b0, 2'b00, lc3b_pkg::ADDR_TRAP, lc3b_pkg::CC_SRC_ALU, 3'b000,
                   rand_word(), {r[7:0], vec}, rand_word());
        end
    endtask

    task automatic test_indirect();
        logic [15:0] p;
        logic [15:0] t;
        for (int i = 0; i < IND_ROUNDS; i++) begin
            p = rand_word();
            t = rand_word();
            if (p[9:1] == t[9:1]) t[5] = ~t[5];  // Keep pointer and target apart
            run_op(1'b0, 1'b1, 2'b11, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b000,
                   p, rand_word(), t);
            run_op(1'b0, 1'b1, 2'b11, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b000,
                   t, rand_word(), rand_word());
            run_op(1'b1, 1'b0, 2'b00, lc3b_pkg::ADDR_ALU, lc3b_pkg::CC_SRC_ALU, 3'b001,
                   p, rand_word(), rand_word());
            run_op(1'b1, 1'b0, 2'b00, lc3b_pkg::ADDR_HELD, lc3b_pkg::CC_SRC_ALU, 3'b000,
                   rand_word(), rand_word(), rand_word());
        end
    endtask

    task automatic test_random_mix();
        logic [31:0] r;
        logic [6:0]  hi;
        logic [1:0]  kind;
        lc3b_pkg::lc3b_addr_sel asel;
        lc3b_pkg::lc3b_cc_sel   csel;
        for (int i = 0; i < MIX_OPS; i++) begin
            r    = rand_bits(2);
            kind = r[1:0];   // 1 read, 2 write, else no memory access
            r    = rand_bits(2);
            asel = (r[1:0] == 2'd0) ? lc3b_pkg::ADDR_TRAP
                 : (r[1:0] == 2'd2) ? lc3b_pkg::ADDR_HELD : lc3b_pkg::ADDR_ALU;
            r    = rand_bits(2);
            csel = (r[1:0] == 2'd1) ? lc3b_pkg::CC_SRC_RDATA
                 : (r[1:0] == 2'd2) ? lc3b_pkg::CC_SRC_STORE : lc3b_pkg::CC_SRC_ALU;
            r    = rand_bits(7);
            hi   = r[6:0];
            r    = rand_bits(6);
            // 64 word addresses so reads often hit earlier writes
            run_op(kind == 2'd1, kind == 2'd2, rand_bits(2) == 32'd3 ? 2'b11 : 2'b01,
                   asel, csel, 3'(rand_bits(3)), {hi, 3'b000, r[5:0]}, rand_word(),
                   cc_word());
        end
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------
    initial begin
        int assert_fails;
        rst_n      = 1'b0;
        start      = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        byte_sel   = 2'b00;
        addr_sel   = lc3b_pkg::ADDR_ALU;
        cc_sel     = lc3b_pkg::CC_SRC_ALU;
        cc_load    = 1'b0;
        br_en_load = 1'b0;
        mdr_load   = 1'b0;
        alu_in     = 16'h0000;
        ir_in      = 16'h0000;
        sr2_in     = 16'h0000;
        for (int i = 0; i < 512; i++) begin
            model_mem[i] = 16'h0000;
        end
        model_cc    = 3'b010;
        model_br_en = 1'b0;
        model_held  = 16'h0000;
        model_mdr   = 16'h0000;
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;

        begin_test();
        test_cond_codes();
        end_test("cond_codes");
        begin_test();
        test_full_words();
        end_test("full_words");
        begin_test();
        test_byte_lanes();
        end_test("byte_lanes");
        begin_test();
        test_trap_vector();
        end_test("trap_vector");
        begin_test();
        test_indirect();
        end_test("indirect");
        begin_test();
        test_random_mix();
        end_test("random_mix");

        assert_fails = dut.u_stage.u_assert.fail_count;
        $display("totals: %0d checks, %0d errors, %0d assertion failures",
                 total_checks, total_errors, assert_fails);
        if (total_errors == 0 && assert_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired, the run took longer than %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+source
source/lc3b_pkg.sv
source/stage_mem.sv
source/line_memory.sv
source/lc3b_mem_top.sv
dv/lc3b_mem_assert.sv
dv/lc3b_mem_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the memory stage testbench

VERILATOR ?= verilator
TB_TOP    ?= lc3b_mem_tb
RTL_TOP   ?= lc3b_mem_top
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

SRCS     := $(shell grep '\.sv$$' $(FILE_LIST))
HDRS     := $(wildcard source/*.svh)
RTL_SRCS := $(filter source/%,$(SRCS))
SIM_BIN  := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HDRS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

run: build
	./$(SIM_BIN) $(RUN_ARGS) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG) || { echo "Simulation did not pass"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Isource $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FILE_LIST) --top-module $(TB_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
